// ==== Makefile ====
SIM  := obj_dir/Vtb_framebuffer
SRCS := $(filter-out +%,$(shell cat build.f)) hdl/fb_settings.svh

.PHONY: all run clean

all: run

$(SIM): build.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_framebuffer -Mdir obj_dir

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/tb_framebuffer.sv ====
`timescale 1ns/1ns
`include "fb_settings.svh"

module tb_framebuffer import fsab_pkg::*, video_pkg::*; ();

	localparam int         FRAME_CYCLES = `FB_H_TOTAL * `FB_V_TOTAL;
	localparam int         RUN_LIMIT_NS = 3 * FRAME_CYCLES * 4 + 400; // Three frames plus start-up
	localparam rgb_t       BORDER       = 24'h0000ff;
	localparam logic [3:0] FOREIGN_DID  = `FB_DID ^ 4'hc;

	logic       fbclk        = 1'b0;
	logic       fbclk_rst_b  = 1'b0;
	logic       fsabo_credit = 1'b0;
	fsab_resp_t fsabi        = '0;
	fsab_req_t  fsabo;
	dvi_word_t  dvi;

	integer seed          = 32'hf8ac_cc45;
	int     value_errors  = 0;
	int     other_errors  = 0;
	int     foreign_beats = 0;

	// Memory model
	logic [30:0] req_q[$];
	logic [30:0] burst_addr;
	int          beat_idx;
	int          gap;
	logic        busy       = 1'b0;
	logic        credit_due = 1'b0;
	fsab_resp_t  beat;

	// Request and video models
	logic        reset_checked = 1'b0;
	int          credits       = `FB_CREDITS;
	logic [30:0] next_addr     = `FB_BASE_ADDR;
	logic        started       = 1'b0;
	int          x;
	int          y;
	int          pix;
	int          frames_done   = 0;
	int          hs_pulses     = 0;
	int          vs_pulses     = 0;
	logic        hs_prev       = 1'b0;
	logic        vs_prev       = 1'b0;

	framebuffer u_framebuffer (
		.fbclk        (fbclk),
		.fbclk_rst_b  (fbclk_rst_b),
		.fsabo        (fsabo),
		.fsabo_credit (fsabo_credit),
		.fsabi        (fsabi),
		.dvi          (dvi)
	);

	always #2 fbclk = ~fbclk;

	// Memory contents, every address bit feeds both halves
	function automatic logic [63:0] word_hash(input logic [30:0] addr);
		logic [31:0] a;
		logic [31:0] lo;
		logic [31:0] hi;
		a  = {1'b0, addr};
		lo = (a * 32'h9e37_79b9) ^ 32'h5bd1_e995;
		hi = ((lo ^ (lo >> 15)) * 32'h85eb_ca6b) + a;
		return {hi, lo};
	endfunction

	// Pixel k of a frame, low slot on even k
	function automatic rgb_t expected_pixel(input int k);
		logic [63:0] w;
		logic [31:0] slot;
		rgb_t        px;
		w        = word_hash(31'(`FB_BASE_ADDR + k / 2));
		slot     = (k % 2 == 0) ? w[31:0] : w[63:32];
		px.red   = slot[31:24];
		px.green = slot[23:16];
		px.blue  = slot[15:8];
		return px;
	endfunction

	function automatic dvi_word_t dvi_from_rgb(input logic vs, input logic hs, input logic de,
			input rgb_t c);
		dvi_word_t d;
		d.vs     = vs;
		d.hs     = hs;
		d.de     = de;
		d.d_rise = {c.green[3:0], c.blue};
		d.d_fall = {c.red, c.green[7:4]};
		return d;
	endfunction

	function automatic string req_text(input fsab_req_t r);
		return $sformatf("valid=%b did=%h addr=%h len=%0d", r.valid, r.did, r.addr, r.len);
	endfunction

	function automatic string dvi_text(input dvi_word_t d);
		return $sformatf("vs=%b hs=%b de=%b rise=%h fall=%h",
			d.vs, d.hs, d.de, d.d_rise, d.d_fall);
	endfunction

	task automatic check_req(input string name, input fsab_req_t exp, input fsab_req_t act);
		if (act !== exp) begin
			value_errors++;
			$display("Fail %s: expected %s, actual %s", name, req_text(exp), req_text(act));
		end
	endtask

	task automatic check_dvi(input string name, input dvi_word_t exp, input dvi_word_t act);
		if (act !== exp) begin
			value_errors++;
			$display("Fail %s: expected %s, actual %s", name, dvi_text(exp), dvi_text(act));
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			value_errors++;
			$display("Fail %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	// Bursts served in order, random latency then short gaps between beats
	always @(posedge fbclk) begin
		fsabo_credit <= credit_due;
		credit_due = 1'b0;
		beat = '0;
		if (fbclk_rst_b) begin
			if (!busy && req_q.size() > 0) begin
				burst_addr = req_q.pop_front();
				beat_idx   = 0;
				gap        = {$random(seed)} % 4;
				busy       = 1'b1;
			end
			if (busy && gap == 0) begin
				beat.valid = 1'b1;
				beat.did   = `FB_DID;
				beat.data  = word_hash(burst_addr + 31'(beat_idx));
				beat_idx++;
				if (beat_idx == `FB_BURST_WORDS) begin
					busy       = 1'b0;
					credit_due = 1'b1; // Credit goes back the cycle after the last beat
				end else begin
					gap = ({$random(seed)} % 4 == 0) ? 1 : 0;
				end
			end else begin
				if (busy)
					gap--;
				if ({$random(seed)} % 3 == 0) begin // Idle slot, another device's beat
					beat.valid = 1'b1;
					beat.did   = FOREIGN_DID;
					beat.data  = {$random(seed), $random(seed)};
					foreign_beats++;
				end
			end
		end
		fsabi <= beat;
	end

	always @(negedge fbclk) begin : req_monitor
		fsab_req_t exp_req;
		if (fbclk_rst_b) begin
			if (!reset_checked) begin
				check_req("request after reset", '0, fsabo);
				reset_checked = 1'b1;
			end
			if (fsabo.valid) begin
				exp_req.valid = 1'b1;
				exp_req.did   = `FB_DID;
				exp_req.addr  = next_addr;
				exp_req.len   = 8'(`FB_BURST_WORDS);
				check_req("burst request", exp_req, fsabo);
				if (credits == 0) begin
					other_errors++;
					$display("Request at %0t ns was issued with no bus credit available", $time);
				end else begin
					credits--;
				end
				req_q.push_back(fsabo.addr);
				if (next_addr + 31'(`FB_BURST_WORDS) == 31'(`FB_BASE_ADDR + `FB_FRAME_WORDS))
					next_addr = `FB_BASE_ADDR;
				else
					next_addr = next_addr + 31'(`FB_BURST_WORDS);
			end
			if (fsabo_credit)
				credits++;
		end
	end

	// Own raster counters, locked to the first displayed pixel
	always @(negedge fbclk) begin : video_monitor
		rgb_t px;
		logic de;
		logic hs;
		logic vs;
		if (fbclk_rst_b && !started && dvi.de) begin
			started = 1'b1;
			x       = 0;
			y       = 0;
			pix     = 0;
		end
		if (fbclk_rst_b && !started) begin
			check_dvi("idle before first frame", dvi_from_rgb(1'b0, 1'b0, 1'b0, BORDER), dvi);
		end else if (started && frames_done < 3) begin
			de = (x < `FB_H_ACTIVE) && (y < `FB_V_ACTIVE);
			hs = (x >= `FB_HS_START) && (x < `FB_HS_END);
			vs = (y >= `FB_VS_START) && (y < `FB_VS_END);
			px = de ? expected_pixel(pix) : BORDER;
			check_dvi($sformatf("frame %0d pixel (%0d,%0d)", frames_done, x, y),
				dvi_from_rgb(vs, hs, de, px), dvi);
			if (de)
				pix++;
			if (x == `FB_H_TOTAL - 1) begin
				x = 0;
				if (y == `FB_V_TOTAL - 1) begin
					y = 0;
					pix = 0;
					frames_done++;
				end else begin
					y++;
				end
			end else begin
				x++;
			end
		end
		if (started && frames_done < 3) begin
			if (dvi.hs && !hs_prev)
				hs_pulses++;
			if (dvi.vs && !vs_prev)
				vs_pulses++;
		end
		hs_prev = dvi.hs;
		vs_prev = dvi.vs;
	end

	initial begin
		repeat (5) @(posedge fbclk);
		fbclk_rst_b <= 1'b1;
		wait (frames_done >= 3);
		@(posedge fbclk);
		check_count("hs pulses over three frames", 3 * `FB_V_TOTAL, hs_pulses);
		check_count("vs pulses over three frames", 3, vs_pulses);
		if (foreign_beats == 0) begin
			other_errors++;
			$display("The memory model never injected a beat from another device");
		end
		$display("Errors: %0d value, %0d protocol (%0d foreign beats injected)",
			value_errors, other_errors, foreign_beats);
		if (value_errors == 0 && other_errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	// Watchdog
	initial begin
		#(RUN_LIMIT_NS);
		$display("Timeout after %0d ns, three frames were not displayed", RUN_LIMIT_NS);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+hdl
hdl/fsab_pkg.sv
hdl/video_pkg.sv
hdl/sync_gen.sv
hdl/frame_dma.sv
hdl/pixel_unpack.sv
hdl/dvi_pack.sv
hdl/framebuffer.sv
bench/tb_framebuffer.sv

// ==== hdl/dvi_pack.sv ====
`timescale 1ns/1ns

module dvi_pack import video_pkg::*; (
	input  logic        fbclk,
	input  logic        fbclk_rst_b,
	input  vid_timing_t timing,
	input  rgb_t        colour,
	output dvi_word_t   dvi
);

	logic vs_q;
	logic hs_q;
	logic de_q;
	rgb_t colour_q;

	always_ff @(posedge fbclk or negedge fbclk_rst_b) begin
		if (!fbclk_rst_b) begin
			vs_q <= 1'b0;
			hs_q <= 1'b0;
			de_q <= 1'b0;
		end else begin
			vs_q <= timing.vs;
			hs_q <= timing.hs;
			de_q <= ~timing.border;
		end
	end

	always_ff @(posedge fbclk)
		colour_q <= colour;

	assign dvi.vs     = vs_q;
	assign dvi.hs     = hs_q;
	assign dvi.de     = de_q;
	assign dvi.d_rise = {colour_q.green[3:0], colour_q.blue};
	assign dvi.d_fall = {colour_q.red, colour_q.green[7:4]};

endmodule

// ==== hdl/fb_settings.svh ====
`ifndef FB_SETTINGS_SVH
`define FB_SETTINGS_SVH

// Frame geometry, kept tiny for simulation
`define FB_H_ACTIVE     8
`define FB_V_ACTIVE     4
`define FB_H_TOTAL      12
`define FB_V_TOTAL      6

// Sync pulse windows, start inclusive and end exclusive
`define FB_HS_START     9
`define FB_HS_END       10
`define FB_VS_START     4
`define FB_VS_END       5

// Memory bus
`define FB_BURST_WORDS  4
`define FB_CREDITS      2
`define FB_FIFO_DEPTH   16
`define FB_BASE_ADDR    31'h0000_0400 // Word address
`define FB_DID          4'h5

// Two pixels per 64-bit word
`define FB_FRAME_WORDS  ((`FB_H_ACTIVE * `FB_V_ACTIVE) / 2)

`endif

// ==== hdl/frame_dma.sv ====
`timescale 1ns/1ns
`include "fb_settings.svh"

module frame_dma import fsab_pkg::*; (
	input  logic        fbclk,
	input  logic        fbclk_rst_b,
	output fsab_req_t   fsabo,
	input  logic        fsabo_credit,
	input  fsab_resp_t  fsabi,
	input  logic        pop,
	output frame_word_u head,
	output logic        fifo_empty
);

	localparam int DEPTH  = `FB_FIFO_DEPTH;
	localparam int PTR_W  = $clog2(DEPTH);
	localparam int CNT_W  = PTR_W + 1;
	localparam int OCC_W  = PTR_W + 2;
	localparam int CRED_W = $clog2(`FB_CREDITS + 1);

	logic [CRED_W-1:0] credits_q;
	logic [CNT_W-1:0]  outstanding_q; // Words requested, not yet arrived
	logic [30:0]       addr_q;
	logic [CNT_W-1:0]  count_q;
	logic [PTR_W-1:0]  wr_ptr_q;
	logic [PTR_W-1:0]  rd_ptr_q;
	logic [63:0]       mem [DEPTH];

	logic [OCC_W-1:0]  occupancy;
	logic              issue;
	logic              push;
	logic              pop_ok;

	// Room for a whole burst on top of what is already promised
	assign occupancy = OCC_W'(count_q) + OCC_W'(outstanding_q) + OCC_W'(`FB_BURST_WORDS);
	assign issue     = (credits_q != '0) && (occupancy <= OCC_W'(DEPTH));

	assign push   = fsabi.valid && (fsabi.did == `FB_DID); // Other devices' beats dropped
	assign pop_ok = pop && !fifo_empty;

	always_ff @(posedge fbclk or negedge fbclk_rst_b) begin
		if (!fbclk_rst_b) begin
			fsabo         <= '0;
			credits_q     <= CRED_W'(`FB_CREDITS);
			outstanding_q <= '0;
			addr_q        <= `FB_BASE_ADDR;
		end else begin
			fsabo.valid <= issue;
			fsabo.did   <= `FB_DID;
			fsabo.addr  <= addr_q;
			fsabo.len   <= 8'(`FB_BURST_WORDS);

			if (issue && !fsabo_credit)
				credits_q <= credits_q - 1'b1;
			else if (!issue && fsabo_credit)
				credits_q <= credits_q + 1'b1;

			outstanding_q <= outstanding_q
				+ (issue ? CNT_W'(`FB_BURST_WORDS) : '0)
				- (push ? CNT_W'(1) : '0);

			if (issue) begin
				if (addr_q == 31'(`FB_BASE_ADDR + `FB_FRAME_WORDS - `FB_BURST_WORDS))
					addr_q <= `FB_BASE_ADDR; // Back to frame start
				else
					addr_q <= addr_q + 31'(`FB_BURST_WORDS);
			end
		end
	end

	always_ff @(posedge fbclk or negedge fbclk_rst_b) begin
		if (!fbclk_rst_b) begin
			count_q  <= '0;
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
		end else begin
			if (push)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (pop_ok)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			if (push && !pop_ok)
				count_q <= count_q + 1'b1;
			else if (!push && pop_ok)
				count_q <= count_q - 1'b1;
		end
	end

	always_ff @(posedge fbclk) begin
		if (push)
			mem[wr_ptr_q] <= fsabi.data;
	end

	// Show-ahead read
	assign head.raw   = mem[rd_ptr_q];
	assign fifo_empty = (count_q == '0);

	a_no_overflow: assert property (
		@(posedge fbclk) disable iff (!fbclk_rst_b)
		push |-> (count_q < CNT_W'(DEPTH)) || pop_ok
	) else $error("frame_dma: FIFO overflow");

	a_no_underflow: assert property (
		@(posedge fbclk) disable iff (!fbclk_rst_b)
		pop |-> !fifo_empty
	) else $error("frame_dma: pop on empty FIFO");

	// Bus returned more credits than were ever handed out
	a_credit_limit: assert property (
		@(posedge fbclk) disable iff (!fbclk_rst_b)
		credits_q <= CRED_W'(`FB_CREDITS)
	) else $error("frame_dma: credit count above limit");

endmodule

// ==== hdl/framebuffer.sv ====
`timescale 1ns/1ns

module framebuffer import fsab_pkg::*, video_pkg::*; (
	input  logic       fbclk,
	input  logic       fbclk_rst_b,
	output fsab_req_t  fsabo,
	input  logic       fsabo_credit,
	input  fsab_resp_t fsabi,
	output dvi_word_t  dvi
);

	logic        fifo_empty;
	logic        fifo_empty_q;
	logic        sync_rst_b;
	logic        pop;
	frame_word_u head;
	vid_timing_t timing;
	vid_timing_t timing_px;
	rgb_t        colour;

	// Video starts once the first word has landed
	always_ff @(posedge fbclk or negedge fbclk_rst_b) begin
		if (!fbclk_rst_b)
			fifo_empty_q <= 1'b1;
		else
			fifo_empty_q <= fifo_empty;
	end

	assign sync_rst_b = fbclk_rst_b && !fifo_empty_q;

	sync_gen u_sync_gen (
		.fbclk  (fbclk),
		.rst_b  (sync_rst_b),
		.timing (timing)
	);

	frame_dma u_frame_dma (
		.fbclk        (fbclk),
		.fbclk_rst_b  (fbclk_rst_b),
		.fsabo        (fsabo),
		.fsabo_credit (fsabo_credit),
		.fsabi        (fsabi),
		.pop          (pop),
		.head         (head),
		.fifo_empty   (fifo_empty)
	);

	pixel_unpack u_pixel_unpack (
		.fbclk       (fbclk),
		.fbclk_rst_b (fbclk_rst_b),
		.timing_in   (timing),
		.head        (head),
		.pop         (pop),
		.timing_out  (timing_px),
		.colour      (colour)
	);

	dvi_pack u_dvi_pack (
		.fbclk       (fbclk),
		.fbclk_rst_b (fbclk_rst_b),
		.timing      (timing_px),
		.colour      (colour),
		.dvi         (dvi)
	);

endmodule

// ==== hdl/fsab_pkg.sv ====
package fsab_pkg;

	// Read request, one cycle per burst
	typedef struct packed {
		logic        valid;
		logic [3:0]  did;
		logic [30:0] addr; // Word address
		logic [7:0]  len;  // Beats in the burst
	} fsab_req_t;

	// One response beat
	typedef struct packed {
		logic        valid;
		logic [3:0]  did;
		logic [63:0] data;
	} fsab_resp_t;

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
		logic [7:0] unused;
	} pix_slot_t;

	// Low slot is displayed first
	typedef struct packed {
		pix_slot_t hi;
		pix_slot_t lo;
	} pix_pair_t;

	typedef union packed {
		logic [63:0] raw;
		pix_pair_t   pixels;
	} frame_word_u;

endpackage

// ==== hdl/pixel_unpack.sv ====
`timescale 1ns/1ns

module pixel_unpack import fsab_pkg::*, video_pkg::*; (
	input  logic        fbclk,
	input  logic        fbclk_rst_b,
	input  vid_timing_t timing_in,
	input  frame_word_u head,
	output logic        pop,
	output vid_timing_t timing_out,
	output rgb_t        colour
);

	logic      half_q; // 0 shows the low slot, 1 the high slot
	pix_slot_t slot;

	always_ff @(posedge fbclk or negedge fbclk_rst_b) begin
		if (!fbclk_rst_b)
			half_q <= 1'b0;
		else if (!timing_in.border)
			half_q <= ~half_q;
	end

	// Word is done after its high slot
	assign pop = !timing_in.border && half_q;

	assign slot = half_q ? head.pixels.hi : head.pixels.lo;

	always_comb begin
		if (timing_in.border) begin
			colour.red   = 8'h00;
			colour.green = 8'h00;
			colour.blue  = 8'hff; // Border is blue
		end else begin
			colour.red   = slot.red;
			colour.green = slot.green;
			colour.blue  = slot.blue;
		end
	end

	assign timing_out = timing_in;

endmodule

// ==== hdl/sync_gen.sv ====
`timescale 1ns/1ns
`include "fb_settings.svh"

module sync_gen import video_pkg::*; (
	input  logic        fbclk,
	input  logic        rst_b,
	output vid_timing_t timing
);

	logic [11:0] x_q;
	logic [11:0] y_q;
	logic        line_end;

	assign line_end = (x_q == 12'(`FB_H_TOTAL - 1));

	// Reset parks on the last blanking pixel so the border is up while held
	always_ff @(posedge fbclk or negedge rst_b) begin
		if (!rst_b) begin
			x_q <= 12'(`FB_H_TOTAL - 1);
			y_q <= 12'(`FB_V_TOTAL - 1);
		end else begin
			if (line_end) begin
				x_q <= '0;
				if (y_q == 12'(`FB_V_TOTAL - 1))
					y_q <= '0;
				else
					y_q <= y_q + 12'd1;
			end else begin
				x_q <= x_q + 12'd1;
			end
		end
	end

	always_comb begin
		timing.x      = x_q;
		timing.y      = y_q;
		timing.border = (x_q >= 12'(`FB_H_ACTIVE)) || (y_q >= 12'(`FB_V_ACTIVE));
		timing.hs     = (x_q >= 12'(`FB_HS_START)) && (x_q < 12'(`FB_HS_END));
		timing.vs     = (y_q >= 12'(`FB_VS_START)) && (y_q < 12'(`FB_VS_END));
	end

	// Line wrap must happen before the counter leaves the line
	a_x_in_line: assert property (
		@(posedge fbclk) disable iff (!rst_b)
		x_q < 12'(`FB_H_TOTAL)
	) else $error("sync_gen: x ran past the line total");

endmodule

// ==== hdl/video_pkg.sv ====
package video_pkg;

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb_t;

	// Timing and position of the current pixel
	typedef struct packed {
		logic        vs;
		logic        hs;
		logic        border; // Outside the active area
		logic [11:0] x;
		logic [11:0] y;
	} vid_timing_t;

	// DVI pins as two half-cycle phases
	//   d_rise : {green[3:0], blue}
	//   d_fall : {red, green[7:4]}
	typedef struct packed {
		logic        vs;
		logic        hs;
		logic        de;
		logic [11:0] d_rise;
		logic [11:0] d_fall;
	} dvi_word_t;

endpackage
